// ==== src/saturn_bus_pkg.sv ====
package saturn_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizing defaults, overridden from the top level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    parameter int PROG_DEPTH_LOG2 = 5;         // 32 entry ring
    parameter int FETCH_NIBBLES   = 4;         // nibbles per fetch word
    parameter int REQ_MAX_WORDS   = 8;         // longest expansion (dp write)

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus program word and host request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic       is_cmd;                    // 1 = command mode, 0 = data
        logic [3:0] nibble;
    } prog_word_t;

    localparam logic REQ_LOAD_PC  = 1'b0;      // load pc, then start reading
    localparam logic REQ_DP_WRITE = 1'b1;      // load dp, write one nibble

    typedef struct packed {
        logic        kind;                     // REQ_LOAD_PC / REQ_DP_WRITE
        logic [19:0] addr;                     // sent low nibble first
        logic [3:0]  data;                     // only used by dp write
    } host_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus command nibbles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [3:0] CMD_PC_READ  = 4'h0;
    localparam logic [3:0] CMD_LOAD_PC  = 4'h4;  // followed by 5 address nibbles
    localparam logic [3:0] CMD_DP_WRITE = 4'h3;
    localparam logic [3:0] CMD_LOAD_DP  = 4'h5;  // followed by 5 address nibbles

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // four phase bus cycle, one-hot
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [3:0] phase_t;

    localparam phase_t PH_SEND   = 4'b0001;    // drive command/data or start read
    localparam phase_t PH_READ   = 4'b0010;    // bus nibble valid, clk_en drops
    localparam phase_t PH_SETTLE = 4'b0100;    // program completion check
    localparam phase_t PH_EXEC   = 4'b1000;    // idle on the bus side

endpackage

// ==== src/saturn_phase_gen.sv ====
`timescale 1ns/1ps

module saturn_phase_gen (
    input  logic                  i_clk,
    input  logic                  i_reset,
    output saturn_bus_pkg::phase_t o_phase
);

    logic phase_err;                           // more or less than one bit set

    // zero, or any two bits set
    assign phase_err = (o_phase == 4'b0000) || ((o_phase & (o_phase - 4'd1)) != 4'b0000);

    always_ff @(posedge i_clk) begin
        if (i_reset || phase_err) begin
            o_phase <= saturn_bus_pkg::PH_SEND;   // restart the cycle
        end else begin
            case (o_phase)
                saturn_bus_pkg::PH_SEND:   o_phase <= saturn_bus_pkg::PH_READ;
                saturn_bus_pkg::PH_READ:   o_phase <= saturn_bus_pkg::PH_SETTLE;
                saturn_bus_pkg::PH_SETTLE: o_phase <= saturn_bus_pkg::PH_EXEC;
                default:                   o_phase <= saturn_bus_pkg::PH_SEND;  // from exec
            endcase
        end
    end

endmodule

// ==== src/saturn_bus_program.sv ====
`timescale 1ns/1ps

module saturn_bus_program #(
    parameter int PROG_DEPTH_LOG2 = saturn_bus_pkg::PROG_DEPTH_LOG2
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_req_valid,
    input  saturn_bus_pkg::host_req_t   i_req,
    input  logic                        i_pop,
    output saturn_bus_pkg::prog_word_t  o_head,
    output logic                        o_empty,
    output logic                        o_req_ready,
    output logic                        o_overflow
);

    localparam int DEPTH = 1 << PROG_DEPTH_LOG2;
    localparam logic [PROG_DEPTH_LOG2:0] MAX_FILL =
        (PROG_DEPTH_LOG2 + 1)'(DEPTH - saturn_bus_pkg::REQ_MAX_WORDS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ring storage, pointers carry one extra wrap bit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    saturn_bus_pkg::prog_word_t ring [DEPTH];
    logic [PROG_DEPTH_LOG2:0]   wr_ptr;
    logic [PROG_DEPTH_LOG2:0]   rd_ptr;
    logic [PROG_DEPTH_LOG2:0]   fill;          // words waiting in the ring

    saturn_bus_pkg::host_req_t  cur_req;       // request being expanded
    logic                       expanding;
    logic [2:0]                 exp_idx;       // word index within expansion
    logic                       exp_last;
    saturn_bus_pkg::prog_word_t exp_word;

    assign fill        = wr_ptr - rd_ptr;
    assign o_empty     = (fill == '0);
    assign o_head      = ring[rd_ptr[PROG_DEPTH_LOG2-1:0]];
    // one request at a time, and room for the longest expansion
    assign o_req_ready = !expanding && (fill <= MAX_FILL);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request expansion, one word per index
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign exp_last = (cur_req.kind == saturn_bus_pkg::REQ_LOAD_PC) ? (exp_idx == 3'd6)
                                                                    : (exp_idx == 3'd7);

    always_comb begin
        exp_word.is_cmd = 1'b1;                // everything but the payload
        case (exp_idx)
            3'd0: exp_word.nibble = (cur_req.kind == saturn_bus_pkg::REQ_LOAD_PC) ?
                                    saturn_bus_pkg::CMD_LOAD_PC : saturn_bus_pkg::CMD_LOAD_DP;
            3'd1: exp_word.nibble = cur_req.addr[3:0];    // low nibble first
            3'd2: exp_word.nibble = cur_req.addr[7:4];
            3'd3: exp_word.nibble = cur_req.addr[11:8];
            3'd4: exp_word.nibble = cur_req.addr[15:12];
            3'd5: exp_word.nibble = cur_req.addr[19:16];
            3'd6: exp_word.nibble = (cur_req.kind == saturn_bus_pkg::REQ_LOAD_PC) ?
                                    saturn_bus_pkg::CMD_PC_READ : saturn_bus_pkg::CMD_DP_WRITE;
            default: begin
                exp_word.is_cmd = 1'b0;        // dp write payload
                exp_word.nibble = cur_req.data;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            expanding  <= 1'b0;
            exp_idx    <= 3'd0;
            o_overflow <= 1'b0;
        end else begin
            if (i_req_valid && o_req_ready) begin
                expanding <= 1'b1;
                exp_idx   <= 3'd0;
            end else if (expanding) begin
                wr_ptr  <= wr_ptr + 1'b1;
                exp_idx <= exp_idx + 3'd1;
                if (exp_last) begin
                    expanding <= 1'b0;
                end
            end
            if (i_pop && !o_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_req_valid && !o_req_ready) begin
                o_overflow <= 1'b1;            // sticky, dropped request
            end
        end
    end

    // payload side, no reset
    always_ff @(posedge i_clk) begin
        if (i_req_valid && o_req_ready) begin
            cur_req <= i_req;
        end
        if (expanding) begin
            ring[wr_ptr[PROG_DEPTH_LOG2-1:0]] <= exp_word;
        end
    end

endmodule

// ==== src/saturn_fetch_unit.sv ====
`timescale 1ns/1ps

module saturn_fetch_unit #(
    parameter int FETCH_NIBBLES = saturn_bus_pkg::FETCH_NIBBLES
) (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_read_en,
    input  logic                       i_read_strobe,
    input  logic [3:0]                 i_bus_nibble_in,
    output logic                       o_no_read,
    output logic                       o_fetch_valid,
    output logic [FETCH_NIBBLES*4-1:0] o_fetch_word
);

    localparam int CNT_W = $clog2(FETCH_NIBBLES + 1);
    localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(FETCH_NIBBLES - 1);

    logic [FETCH_NIBBLES*4-1:0] assembly;     // shifts right, newest on top
    logic [FETCH_NIBBLES*4-1:0] assembly_next;
    logic [CNT_W-1:0]           nib_cnt;
    logic                       word_done;

    assign o_no_read     = !i_read_en;
    assign assembly_next = {i_bus_nibble_in, assembly[FETCH_NIBBLES*4-1:4]};
    assign word_done     = i_read_strobe && i_read_en && (nib_cnt == LAST_NIB);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // nibble count and valid pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            nib_cnt       <= '0;
            o_fetch_valid <= 1'b0;
        end else begin
            o_fetch_valid <= word_done;        // one cycle after last strobe
            if (!i_read_en) begin
                nib_cnt <= '0;                 // drop partial word
            end else if (i_read_strobe) begin
                nib_cnt <= word_done ? '0 : nib_cnt + 1'b1;
            end
        end
    end

    // word assembly, first nibble ends lowest
    always_ff @(posedge i_clk) begin
        if (i_read_strobe) begin
            assembly <= assembly_next;
        end
        if (word_done) begin
            o_fetch_word <= assembly_next;
        end
    end

endmodule

// ==== src/saturn_bus_controller.sv ====
`timescale 1ns/1ps

module saturn_bus_controller (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  saturn_bus_pkg::phase_t     i_phase,
    input  saturn_bus_pkg::prog_word_t i_head,
    input  logic                       i_empty,
    output logic                       o_pop,
    input  logic                       i_no_read,
    input  logic                       i_overflow,
    output logic                       o_read_strobe,
    output logic                       o_bus_clk_en,
    output logic                       o_bus_is_data,
    output logic [3:0]                 o_bus_nibble_out,
    output logic                       o_halt
);

    logic busy;                                // a program is on its way out
    logic read_pend;                           // read started in send phase
    logic stop;

    // overflow stops the bus before halt is registered
    assign stop = o_halt || i_overflow;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-phase bus sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bus_clk_en  <= 1'b0;
            o_pop         <= 1'b0;
            o_read_strobe <= 1'b0;
            busy          <= 1'b0;
            read_pend     <= 1'b0;
            o_halt        <= 1'b0;
        end else begin
            o_pop         <= 1'b0;             // both are single pulses
            o_read_strobe <= 1'b0;
            if (i_overflow) begin
                o_halt <= 1'b1;                // sticky until reset
            end
            case (i_phase)
                saturn_bus_pkg::PH_SEND: begin
                    if (!stop && !i_empty) begin
                        o_pop        <= 1'b1;  // write wins over read
                        o_bus_clk_en <= 1'b1;
                        busy         <= 1'b1;
                    end else if (!stop && !i_no_read && !busy) begin
                        o_bus_clk_en <= 1'b1;  // read cycle
                        read_pend    <= 1'b1;
                    end
                end
                saturn_bus_pkg::PH_READ: begin
                    o_bus_clk_en <= 1'b0;      // one cycle of clk_en per bus cycle
                    if (read_pend) begin
                        o_read_strobe <= 1'b1;
                        read_pend     <= 1'b0;
                    end
                end
                saturn_bus_pkg::PH_SETTLE: begin
                    if (i_empty) begin
                        busy <= 1'b0;          // whole program sent
                    end
                end
                default: begin
                    o_bus_clk_en <= 1'b0;      // exec phase, bus idle
                end
            endcase
        end
    end

    // bus payload, no reset
    always_ff @(posedge i_clk) begin
        if (i_phase == saturn_bus_pkg::PH_SEND && !stop && !i_empty) begin
            o_bus_nibble_out <= i_head.nibble;
            o_bus_is_data    <= !i_head.is_cmd;
        end
    end

endmodule

// ==== src/saturn_bus_top.sv ====
`timescale 1ns/1ps

module saturn_bus_top #(
    parameter int PROG_DEPTH_LOG2 = saturn_bus_pkg::PROG_DEPTH_LOG2,
    parameter int FETCH_NIBBLES   = saturn_bus_pkg::FETCH_NIBBLES
) (
    input  logic                       i_clk,
    input  logic                       i_reset,
    // host side
    input  logic                       i_req_valid,
    input  saturn_bus_pkg::host_req_t  i_req,
    input  logic                       i_read_en,
    output logic                       o_req_ready,
    output logic                       o_fetch_valid,
    output logic [FETCH_NIBBLES*4-1:0] o_fetch_word,
    output logic                       o_halt,
    // nibble bus
    output logic                       o_bus_clk_en,
    output logic                       o_bus_is_data,
    output logic [3:0]                 o_bus_nibble_out,
    input  logic [3:0]                 i_bus_nibble_in
);

    saturn_bus_pkg::phase_t     phase;
    saturn_bus_pkg::prog_word_t head;
    logic                       empty;
    logic                       pop;
    logic                       overflow;
    logic                       no_read;
    logic                       read_strobe;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // phase source, program and fetch side by side, controller joins them
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    saturn_phase_gen u_phase_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_phase (phase)
    );

    saturn_bus_program #(
        .PROG_DEPTH_LOG2 (PROG_DEPTH_LOG2)
    ) u_bus_program (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .i_req       (i_req),
        .i_pop       (pop),
        .o_head      (head),
        .o_empty     (empty),
        .o_req_ready (o_req_ready),
        .o_overflow  (overflow)
    );

    saturn_fetch_unit #(
        .FETCH_NIBBLES (FETCH_NIBBLES)
    ) u_fetch_unit (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_read_en       (i_read_en),
        .i_read_strobe   (read_strobe),
        .i_bus_nibble_in (i_bus_nibble_in),
        .o_no_read       (no_read),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_word    (o_fetch_word)
    );

    saturn_bus_controller u_bus_controller (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_phase          (phase),
        .i_head           (head),
        .i_empty          (empty),
        .o_pop            (pop),
        .i_no_read        (no_read),
        .i_overflow       (overflow),
        .o_read_strobe    (read_strobe),
        .o_bus_clk_en     (o_bus_clk_en),
        .o_bus_is_data    (o_bus_is_data),
        .o_bus_nibble_out (o_bus_nibble_out),
        .o_halt           (o_halt)
    );

endmodule

// ==== tb/saturn_bus_properties.sv ====
`timescale 1ns/1ps

module saturn_bus_properties (
    input logic i_clk,
    input logic i_reset,
    input logic i_bus_clk_en,
    input logic i_fetch_valid,
    input logic i_halt,
    input logic i_req_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    reset_state: assert property (@(posedge i_clk)
        $fell(i_reset) |-> !i_bus_clk_en && !i_fetch_valid && !i_halt && i_req_ready)
        else $error("outputs not at their reset values after reset");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one clk_en cycle per bus cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    clk_en_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_bus_clk_en |=> !i_bus_clk_en)
        else $error("clk_en high in two consecutive cycles");

    clk_en_spacing: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_bus_clk_en) |-> !$past(i_bus_clk_en, 2) && !$past(i_bus_clk_en, 3))
        else $error("clk_en rose again less than 4 cycles apart");   // last rise 4 back

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // halt behavior
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    halt_sticky: assert property (@(posedge i_clk) disable iff (i_reset)
        i_halt |=> i_halt)
        else $error("halt dropped without a reset");

    halt_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
        i_halt |-> !i_bus_clk_en)                                   // bus frozen
        else $error("clk_en high while halted");

endmodule

bind saturn_bus_top saturn_bus_properties u_props (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_bus_clk_en  (o_bus_clk_en),
    .i_fetch_valid (o_fetch_valid),
    .i_halt        (o_halt),
    .i_req_ready   (o_req_ready)
);

// ==== tb/saturn_bus_tb.sv ====
`timescale 1ns/1ps

module saturn_bus_tb;

    localparam int PROG_DEPTH_LOG2 = 5;
    localparam int FETCH_NIBBLES   = 4;
    localparam int CYCLE_LIMIT     = 6000;      // 4 cycles x ~1500 bus phases
    localparam int N_FETCH         = 3;         // fetch words collected

    logic                       i_clk;
    logic                       i_reset;
    logic                       i_req_valid;
    saturn_bus_pkg::host_req_t  i_req;
    logic                       i_read_en;
    logic                       o_req_ready;
    logic                       o_fetch_valid;
    logic [FETCH_NIBBLES*4-1:0] o_fetch_word;
    logic                       o_halt;
    logic                       o_bus_clk_en;
    logic                       o_bus_is_data;
    logic [3:0]                 o_bus_nibble_out;
    logic [3:0]                 i_bus_nibble_in;

    logic [3:0]  mem [1024];                    // bus memory model
    logic [19:0] pc;
    logic [19:0] dp;
    int          dec_state;                     // 0 cmd, 1 address, 2 data
    int          addr_cnt;
    logic        addr_to_pc;
    logic        reading;                       // clk_en cycles are reads
    int          rd_cnt;
    logic [4:0]  bus_words [$];                 // {is_data, nibble}
    logic [FETCH_NIBBLES*4-1:0] fetch_words [$];
    int          clk_en_seen;
    int          cycles;
    int          errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    saturn_bus_top #(
        .PROG_DEPTH_LOG2 (PROG_DEPTH_LOG2),
        .FETCH_NIBBLES   (FETCH_NIBBLES)
    ) UUT (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_req_valid      (i_req_valid),
        .i_req            (i_req),
        .i_read_en        (i_read_en),
        .o_req_ready      (o_req_ready),
        .o_fetch_valid    (o_fetch_valid),
        .o_fetch_word     (o_fetch_word),
        .o_halt           (o_halt),
        .o_bus_clk_en     (o_bus_clk_en),
        .o_bus_is_data    (o_bus_is_data),
        .o_bus_nibble_out (o_bus_nibble_out),
        .i_bus_nibble_in  (i_bus_nibble_in)
    );

    always #20 i_clk = !i_clk;                  // 40 ns period

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus memory model, decodes the command stream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge i_clk) begin
        logic [19:0] a;
        #1;
        if (o_fetch_valid) begin
            fetch_words.push_back(o_fetch_word);
        end
        if (o_bus_clk_en) begin
            clk_en_seen = clk_en_seen + 1;
            if (reading) begin
                a = pc + 20'(rd_cnt);           // pc plus read count
                i_bus_nibble_in = mem[a[9:0]];
                rd_cnt = rd_cnt + 1;
            end else begin
                bus_words.push_back({o_bus_is_data, o_bus_nibble_out});
                if (dec_state == 1) begin
                    if (addr_to_pc) pc[addr_cnt*4 +: 4] = o_bus_nibble_out;
                    else dp[addr_cnt*4 +: 4] = o_bus_nibble_out;
                    addr_cnt = addr_cnt + 1;
                    if (addr_cnt == 5) dec_state = 0;
                end else if (dec_state == 2) begin
                    mem[dp[9:0]] = o_bus_nibble_out;      // dp write payload
                    dec_state = 0;
                end else if (o_bus_nibble_out == saturn_bus_pkg::CMD_LOAD_PC) begin
                    addr_to_pc = 1'b1;
                    addr_cnt   = 0;
                    dec_state  = 1;
                end else if (o_bus_nibble_out == saturn_bus_pkg::CMD_LOAD_DP) begin
                    addr_to_pc = 1'b0;
                    addr_cnt   = 0;
                    dec_state  = 1;
                end else if (o_bus_nibble_out == saturn_bus_pkg::CMD_PC_READ) begin
                    reading = 1'b1;
                    rd_cnt  = 0;
                end else if (o_bus_nibble_out == saturn_bus_pkg::CMD_DP_WRITE) begin
                    dec_state = 2;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic step(input int n);
        repeat (n) @(posedge i_clk);
        #2;                                     // drive after the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic send_request(input logic kind, input logic [19:0] addr,
                                input logic [3:0] data);
        while (!o_req_ready) step(1);
        i_req.kind  = kind;
        i_req.addr  = addr;
        i_req.data  = data;
        i_req_valid = 1'b1;
        step(1);
        i_req_valid = 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run = tests_run + 1;
        if (errors != errs_before) begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [19:0] addr;
        logic [19:0] a;
        logic [3:0]  data;
        logic [4:0]  exp_words [8];
        logic [FETCH_NIBBLES*4-1:0] exp_word;
        logic [9:0]  idx;
        int          e0;

        i_clk = 1'b0;
        i_reset = 1'b1;
        i_req_valid = 1'b0;
        i_req = '0;
        i_read_en = 1'b0;
        i_bus_nibble_in = 4'h0;
        pc = '0;
        dp = '0;
        dec_state = 0;
        addr_cnt = 0;
        addr_to_pc = 1'b0;
        reading = 1'b0;
        rd_cnt = 0;
        clk_en_seen = 0;
        cycles = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 82116;
        for (int i = 0; i < 1024; i++) begin
            idx = 10'(i);
            mem[i] = idx[3:0] ^ idx[7:4] ^ {idx[9:8], 2'b10};     // whole address
        end
        step(16);
        i_reset = 1'b0;
        step(2);
        end_test("reset_state", errors);        // checked by property

        // dp write expansion, read_en low so every clk_en is a program word
        e0 = errors;
        addr = 20'($random(seed));
        data = 4'($random(seed));
        exp_words[0] = {1'b0, saturn_bus_pkg::CMD_LOAD_DP};
        for (int k = 0; k < 5; k++) exp_words[k+1] = {1'b0, addr[k*4 +: 4]};
        exp_words[6] = {1'b0, saturn_bus_pkg::CMD_DP_WRITE};
        exp_words[7] = {1'b1, data};
        bus_words.delete();
        send_request(saturn_bus_pkg::REQ_DP_WRITE, addr, data);
        while (bus_words.size() < 8) step(1);
        step(12);                               // nothing extra may follow
        check_value("write_expansion count", 8, bus_words.size());
        for (int k = 0; k < 8; k++) begin
            check_value("write_expansion word", 32'(exp_words[k]), 32'(bus_words[k]));
        end
        end_test("write_expansion", e0);

        // load pc, then read once the model has seen pc_read
        e0 = errors;
        addr = 20'($random(seed));
        fetch_words.delete();
        send_request(saturn_bus_pkg::REQ_LOAD_PC, addr, 4'h0);
        while (!reading) step(1);
        i_read_en = 1'b1;
        while (fetch_words.size() < N_FETCH) step(1);
        i_read_en = 1'b0;
        for (int k = 0; k < N_FETCH; k++) begin
            for (int j = 0; j < FETCH_NIBBLES; j++) begin
                a = addr + 20'(k * FETCH_NIBBLES + j);
                exp_word[j*4 +: 4] = mem[a[9:0]];                // first nibble lowest
            end
            check_value("fetch_words", 32'(exp_word), 32'(fetch_words[k]));
        end
        end_test("fetch_words", e0);

        // read gating, ring empty and reads off
        e0 = errors;
        step(12);                               // let the last read finish
        reading = 1'b0;
        clk_en_seen = 0;
        fetch_words.delete();
        step(60);
        check_value("read_gating clk_en", 0, clk_en_seen);
        check_value("read_gating fetch_valid", 0, fetch_words.size());
        end_test("read_gating", e0);

        // overflow, second strobe while the first is still expanding
        e0 = errors;
        send_request(saturn_bus_pkg::REQ_DP_WRITE, 20'($random(seed)), 4'h5);
        check_value("overflow ready", 0, 32'(o_req_ready));
        i_req_valid = 1'b1;
        step(1);
        i_req_valid = 1'b0;
        step(3);
        check_value("overflow halt", 1, 32'(o_halt));
        step(8);                                // clk_en already set drains out
        clk_en_seen = 0;
        step(100);
        check_value("overflow clk_en", 0, clk_en_seen);
        check_value("overflow halt held", 1, 32'(o_halt));
        end_test("overflow", e0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/saturn_bus_pkg.sv
src/saturn_phase_gen.sv
src/saturn_bus_program.sv
src/saturn_fetch_unit.sv
src/saturn_bus_controller.sv
src/saturn_bus_top.sv
tb/saturn_bus_properties.sv
tb/saturn_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the saturn bus testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module saturn_bus_tb \
    -f filelist.f -o saturn_bus_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/saturn_bus_sim | tee sim.log
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
exit 0
